/* design/dbg_defs.svh */
`ifndef DBG_DEFS_SVH
`define DBG_DEFS_SVH

////////////////////
// serial line

`define DBG_CLKS_PER_BIT 16

////////////////////
// memory sizes

`define DBG_IM_DEPTH     16
`define DBG_DM_DEPTH     8
`define DBG_NUM_REGS     8

////////////////////
// host commands, ascii

`define DBG_CMD_LOAD     8'h4c
`define DBG_CMD_RUN      8'h52
`define DBG_CMD_STEP     8'h53
`define DBG_CMD_DUMP     8'h44

`define DBG_DUMP_BYTES   68   // pc word, 8 registers, 8 memory words

`endif

/* design/dbg_pkg.sv */
package dbg_pkg;

    typedef logic [7:0]  byte_t;      // one serial byte
    typedef logic [31:0] word_t;
    typedef logic [3:0]  im_addr_t;   // also the width of the pc
    typedef logic [2:0]  reg_addr_t;
    typedef logic [2:0]  dm_addr_t;

    // encodings not listed here run as a no-op, so a zeroed word is harmless
    typedef enum logic [3:0] {
        OP_ADD  = 4'h1,
        OP_ADDI = 4'h2,
        OP_LW   = 4'h3,
        OP_SW   = 4'h4,
        OP_HLT  = 4'hf
    } opcode_t;

    typedef enum logic [2:0] {
        DU_IDLE       = 3'd0,
        DU_LOAD_COUNT = 3'd1,
        DU_LOAD_BYTES = 3'd2,
        DU_RUN        = 3'd3,
        DU_STEP       = 3'd4,
        DU_DUMP       = 3'd5
    } du_state_t;

    typedef struct packed {
        logic      exec_enable;
        logic      clear;       // zeroes pc, halt, registers and data memory
        logic      im_write;
        im_addr_t  im_addr;
        word_t     im_wdata;
        reg_addr_t dbg_reg_addr;
        dm_addr_t  dbg_dm_addr;
    } dp_ctrl_t;

    typedef struct packed {
        im_addr_t pc;
        logic     halt;
        word_t    reg_data;
        word_t    dm_data;
    } dp_status_t;

endpackage

/* design/uart_rx.sv */
`timescale 1ns/1ns
`include "dbg_defs.svh"

module uart_rx import dbg_pkg::*; (
    input  logic  i_clock,
    input  logic  i_reset,
    input  logic  i_rx,
    output byte_t o_rx_data,
    output logic  o_rx_done
);

    localparam int TICK_W = $clog2(`DBG_CLKS_PER_BIT);
    localparam int HALF   = `DBG_CLKS_PER_BIT / 2;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_t;

    rx_state_t         state;
    logic [1:0]        sync;        // sync[1] is the usable line level
    logic [TICK_W-1:0] tick;
    logic [2:0]        bit_idx;
    byte_t             shift;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state     <= RX_IDLE;
            sync      <= 2'b11;
            tick      <= '0;
            bit_idx   <= '0;
            o_rx_done <= 1'b0;
        end else begin
            sync      <= {sync[0], i_rx};
            o_rx_done <= 1'b0;
            case (state)
                RX_IDLE: begin
                    tick <= '0;
                    if (!sync[1]) state <= RX_START;
                end
                RX_START: begin
                    if (tick == TICK_W'(HALF - 1)) begin   // centre of the start bit
                        tick    <= '0;
                        bit_idx <= '0;
                        state   <= sync[1] ? RX_IDLE : RX_DATA;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                RX_DATA: begin
                    if (tick == TICK_W'(`DBG_CLKS_PER_BIT - 1)) begin
                        tick    <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= RX_STOP;
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
                default: begin
                    if (tick == TICK_W'(`DBG_CLKS_PER_BIT - 1)) begin
                        state     <= RX_IDLE;
                        o_rx_done <= sync[1];    // a low stop bit drops the frame
                    end else begin
                        tick <= tick + 1'b1;
                    end
                end
            endcase
        end
    end

    // lsb arrives first
    always_ff @(posedge i_clock) begin
        if (state == RX_DATA && tick == TICK_W'(`DBG_CLKS_PER_BIT - 1)) begin
            shift <= {sync[1], shift[7:1]};
        end
    end

    assign o_rx_data = shift;

    a_done_single: assert property (@(posedge i_clock) disable iff (i_reset)
        o_rx_done |=> !o_rx_done);

endmodule

/* design/uart_tx.sv */
`timescale 1ns/1ns
`include "dbg_defs.svh"

module uart_tx import dbg_pkg::*; (
    input  logic  i_clock,
    input  logic  i_reset,
    input  byte_t i_tx_data,
    input  logic  i_tx_start,
    output logic  o_tx,
    output logic  o_tx_done
);

    localparam int TICK_W = $clog2(`DBG_CLKS_PER_BIT);

    logic [9:0]        frame;      // stop, data, start with the start bit at 0
    logic [3:0]        bit_cnt;
    logic [TICK_W-1:0] tick;
    logic              busy;

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            frame     <= '1;
            bit_cnt   <= '0;
            tick      <= '0;
            busy      <= 1'b0;
            o_tx_done <= 1'b0;
        end else begin
            o_tx_done <= 1'b0;
            if (!busy) begin
                if (i_tx_start) begin
                    frame   <= {1'b1, i_tx_data, 1'b0};
                    bit_cnt <= '0;
                    tick    <= '0;
                    busy    <= 1'b1;
                end
            end else if (tick == TICK_W'(`DBG_CLKS_PER_BIT - 1)) begin
                tick  <= '0;
                frame <= {1'b1, frame[9:1]};   // idle level fills in behind
                if (bit_cnt == 4'd9) begin
                    busy      <= 1'b0;
                    o_tx_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end else begin
                tick <= tick + 1'b1;
            end
        end
    end

    assign o_tx = frame[0];

    // the sender has to wait for o_tx_done before the next byte
    a_start_idle: assert property (@(posedge i_clock) disable iff (i_reset)
        i_tx_start |-> !busy);

endmodule

/* design/debug_unit.sv */
`timescale 1ns/1ns
`include "dbg_defs.svh"

module debug_unit import dbg_pkg::*; (
    input  logic       i_clock,
    input  logic       i_reset,
    input  byte_t      i_rx_data,
    input  logic       i_rx_done,
    input  logic       i_tx_done,
    input  dp_status_t i_status,
    output dp_ctrl_t   o_ctrl,
    output byte_t      o_tx_data,
    output logic       o_tx_start,
    output du_state_t  o_state
);

    localparam int LAST_BYTE = `DBG_DUMP_BYTES - 1;

    du_state_t   state;
    logic        clear_q;
    byte_t       words_left;
    im_addr_t    load_addr;
    logic [1:0]  byte_sel;
    logic [23:0] wdata;        // first three bytes of the word being loaded
    logic [6:0]  dump_idx;
    logic        tx_busy;
    logic [4:0]  word_idx;
    reg_addr_t   dbg_addr;
    word_t       dump_word;
    logic        im_write;

    ////////////////////
    // dump byte select

    assign word_idx = dump_idx[6:2];            // 0 is pc, 1..8 regs, 9..16 memory
    assign dbg_addr = reg_addr_t'(word_idx - 5'd1); // regs and memory share the low bits

    always_comb begin
        if (word_idx == 5'd0) begin
            dump_word = {28'd0, i_status.pc};
        end else if (word_idx <= 5'd8) begin
            dump_word = i_status.reg_data;
        end else begin
            dump_word = i_status.dm_data;
        end
    end

    ////////////////////
    // data path control

    assign im_write = (state == DU_LOAD_BYTES) && i_rx_done && (byte_sel == 2'd3);

    always_comb begin
        o_ctrl.exec_enable  = ((state == DU_RUN) || (state == DU_STEP)) && !i_status.halt;
        o_ctrl.clear        = clear_q;
        o_ctrl.im_write     = im_write;
        o_ctrl.im_addr      = load_addr;
        o_ctrl.im_wdata     = {i_rx_data, wdata};  // last byte straight off the line
        o_ctrl.dbg_reg_addr = dbg_addr;
        o_ctrl.dbg_dm_addr  = dbg_addr;
    end

    assign o_state = state;

    ////////////////////
    // command fsm

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state      <= DU_IDLE;
            clear_q    <= 1'b0;
            words_left <= '0;
            load_addr  <= '0;
            byte_sel   <= '0;
            dump_idx   <= '0;
            tx_busy    <= 1'b0;
            o_tx_start <= 1'b0;
        end else begin
            clear_q    <= 1'b0;
            o_tx_start <= 1'b0;
            case (state)
                DU_IDLE: begin
                    dump_idx <= '0;
                    tx_busy  <= 1'b0;
                    if (i_rx_done) begin
                        case (i_rx_data)
                            `DBG_CMD_LOAD: begin
                                state   <= DU_LOAD_COUNT;
                                clear_q <= 1'b1;
                            end
                            `DBG_CMD_RUN:  state <= DU_RUN;
                            `DBG_CMD_STEP: state <= DU_STEP;
                            `DBG_CMD_DUMP: state <= DU_DUMP;
                            default: ;                // unknown bytes are ignored
                        endcase
                    end
                end
                DU_LOAD_COUNT: begin
                    load_addr <= '0;
                    byte_sel  <= '0;
                    if (i_rx_done) begin
                        words_left <= i_rx_data;
                        state      <= (i_rx_data == 8'd0) ? DU_IDLE : DU_LOAD_BYTES;
                    end
                end
                DU_LOAD_BYTES: begin
                    if (i_rx_done) begin
                        byte_sel <= byte_sel + 1'b1;
                        if (im_write) begin
                            load_addr  <= load_addr + 1'b1;
                            words_left <= words_left - 1'b1;
                            if (words_left == 8'd1) state <= DU_IDLE;
                        end
                    end
                end
                DU_RUN: begin
                    if (i_status.halt) state <= DU_DUMP;
                end
                DU_STEP: state <= DU_DUMP;  // the single execute happens this cycle
                default: begin
                    if (!tx_busy) begin
                        o_tx_start <= 1'b1;
                        tx_busy    <= 1'b1;
                    end else if (i_tx_done) begin
                        tx_busy <= 1'b0;
                        if (dump_idx == 7'(LAST_BYTE)) begin
                            state <= DU_IDLE;
                        end else begin
                            dump_idx <= dump_idx + 7'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clock) begin
        if (state == DU_LOAD_BYTES && i_rx_done) begin
            wdata <= {i_rx_data, wdata[23:8]};
        end
        if (state == DU_DUMP && !tx_busy) begin
            o_tx_data <= dump_word[8*dump_idx[1:0] +: 8];  // lsb of each word goes first
        end
    end

    a_write_in_load: assert property (@(posedge i_clock) disable iff (i_reset)
        o_ctrl.im_write |-> (state == DU_LOAD_BYTES));

    a_no_exec_halted: assert property (@(posedge i_clock) disable iff (i_reset)
        o_ctrl.exec_enable |-> !i_status.halt);

endmodule

/* design/data_path.sv */
`timescale 1ns/1ns
`include "dbg_defs.svh"

module data_path import dbg_pkg::*; (
    input  logic       i_clock,
    input  logic       i_reset,
    input  dp_ctrl_t   i_ctrl,
    output dp_status_t o_status
);

    word_t     im [`DBG_IM_DEPTH];
    word_t     rb [`DBG_NUM_REGS];
    word_t     dm [`DBG_DM_DEPTH];
    im_addr_t  pc;
    logic      halt;
    word_t     instr;
    opcode_t   opcode;
    reg_addr_t rd;
    reg_addr_t rs;
    reg_addr_t rt;
    dm_addr_t  mem_addr;
    word_t     imm_ext;
    word_t     rs_val;
    word_t     rt_val;
    logic      wb_en;
    word_t     wb_data;

    ////////////////////
    // decode

    assign instr    = im[pc];
    assign opcode   = opcode_t'(instr[31:28]);
    assign rd       = instr[26:24];
    assign rs       = instr[22:20];
    assign rt       = instr[18:16];
    assign mem_addr = instr[2:0];
    assign imm_ext  = {{16{instr[15]}}, instr[15:0]};
    assign rs_val   = rb[rs];
    assign rt_val   = rb[rt];

    always_comb begin
        wb_en   = 1'b0;
        wb_data = '0;
        case (opcode)
            OP_ADD: begin
                wb_en   = 1'b1;
                wb_data = rs_val + rt_val;
            end
            OP_ADDI: begin
                wb_en   = 1'b1;
                wb_data = rs_val + imm_ext;
            end
            OP_LW: begin
                wb_en   = 1'b1;
                wb_data = dm[mem_addr];
            end
            default: ;
        endcase
    end

    ////////////////////
    // execute

    // instruction memory only changes from the debug side
    always_ff @(posedge i_clock) begin
        if (i_ctrl.im_write) im[i_ctrl.im_addr] <= i_ctrl.im_wdata;
    end

    always_ff @(posedge i_clock) begin
        if (i_reset || i_ctrl.clear) begin
            pc   <= '0;
            halt <= 1'b0;
            for (int i = 0; i < `DBG_NUM_REGS; i++) rb[i] <= '0;
            for (int i = 0; i < `DBG_DM_DEPTH; i++) dm[i] <= '0;
        end else if (i_ctrl.exec_enable && !halt) begin
            if (wb_en && rd != 3'd0) rb[rd] <= wb_data;   // r0 stays zero
            if (opcode == OP_SW) dm[mem_addr] <= rs_val;
            if (opcode == OP_HLT) begin
                halt <= 1'b1;                              // pc holds on the hlt
            end else begin
                pc <= pc + 1'b1;
            end
        end
    end

    always_comb begin
        o_status.pc       = pc;
        o_status.halt     = halt;
        o_status.reg_data = rb[i_ctrl.dbg_reg_addr];
        o_status.dm_data  = dm[i_ctrl.dbg_dm_addr];
    end

endmodule

/* design/debug_top.sv */
`timescale 1ns/1ns

module debug_top import dbg_pkg::*; (
    input  logic      i_clock,
    input  logic      i_reset,
    input  logic      i_uart_rx,
    output logic      o_uart_tx,
    output logic      o_hlt,
    output du_state_t o_state
);

    byte_t      rx_data;
    byte_t      tx_data;
    logic       rx_done;
    logic       tx_done;
    logic       tx_start;
    dp_ctrl_t   ctrl;
    dp_status_t status;

    uart_rx u_uart_rx (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_rx      (i_uart_rx),
        .o_rx_data (rx_data),
        .o_rx_done (rx_done)
    );

    uart_tx u_uart_tx (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_tx_data  (tx_data),
        .i_tx_start (tx_start),
        .o_tx       (o_uart_tx),
        .o_tx_done  (tx_done)
    );

    debug_unit u_debug_unit (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .i_rx_data  (rx_data),
        .i_rx_done  (rx_done),
        .i_tx_done  (tx_done),
        .i_status   (status),
        .o_ctrl     (ctrl),
        .o_tx_data  (tx_data),
        .o_tx_start (tx_start),
        .o_state    (o_state)
    );

    data_path u_data_path (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_ctrl   (ctrl),
        .o_status (status)
    );

    assign o_hlt = status.halt;

endmodule

/* verification/debug_top_tb.sv */
`timescale 1ns/1ns
`include "dbg_defs.svh"

module debug_top_tb import dbg_pkg::*; ();

    localparam int CLKS     = `DBG_CLKS_PER_BIT;
    localparam int DUMP     = `DBG_DUMP_BYTES;
    localparam int PROG_LEN = 8;
    localparam int BYTE_CYC = 10 * CLKS;

    // serial bytes per test, both directions
    localparam int TOTAL_BYTES = (2 + 1 + DUMP)
                               + (2 + 4 * PROG_LEN + 1 + DUMP)
                               + (2 + 4 * PROG_LEN + (PROG_LEN + 1) * (1 + DUMP))
                               + (1 + 2 + 1 + DUMP);
    localparam longint WATCHDOG_NS = 2 * TOTAL_BYTES * BYTE_CYC * 8;

    logic      i_clock;
    logic      i_reset;
    logic      i_uart_rx;
    logic      o_uart_tx;
    logic      o_hlt;
    du_state_t o_state;

    byte_t     dump_q [DUMP];
    word_t     prog [`DBG_IM_DEPTH];
    word_t     m_rb [`DBG_NUM_REGS];
    word_t     m_dm [`DBG_DM_DEPTH];
    im_addr_t  m_pc;
    logic      m_halt;
    word_t     lcg_state = 32'd77;
    int        err_count = 0;
    int        tests_run = 0;
    int        tests_failed = 0;

    debug_top DUT (
        .i_clock   (i_clock),
        .i_reset   (i_reset),
        .i_uart_rx (i_uart_rx),
        .o_uart_tx (o_uart_tx),
        .o_hlt     (o_hlt),
        .o_state   (o_state)
    );

    always #4 i_clock = ~i_clock;

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the DUT stopped answering", WATCHDOG_NS);
        $display("Some tests failed");
        $finish;
    end

    ////////////////////
    // compare tasks

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected 0x%02h actual 0x%02h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected 0x%08h actual 0x%08h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_state(input string name, input du_state_t exp, input du_state_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (err_count == errs_before) begin
            $display("test %s: PASS", name);
        end else begin
            tests_failed++;
            $display("test %s: FAIL", name);
        end
    endtask

    ////////////////////
    // reference model

    function automatic word_t next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic word_t encode_instr(input opcode_t op, input reg_addr_t rd,
                                           input reg_addr_t rs, input reg_addr_t rt,
                                           input logic [15:0] imm);
        return {op, 1'b0, rd, 1'b0, rs, 1'b0, rt, imm};
    endfunction

    task automatic model_clear();
        m_pc   = '0;
        m_halt = 1'b0;
        for (int i = 0; i < `DBG_NUM_REGS; i++) m_rb[i] = '0;
        for (int i = 0; i < `DBG_DM_DEPTH; i++) m_dm[i] = '0;
    endtask

    task automatic model_step();
        word_t     instr;
        reg_addr_t rd;
        reg_addr_t rs;
        reg_addr_t rt;
        word_t     imm;
        if (m_halt) return;   // a halted core ignores steps
        instr = prog[m_pc];
        rd    = instr[26:24];
        rs    = instr[22:20];
        rt    = instr[18:16];
        imm   = {{16{instr[15]}}, instr[15:0]};
        case (instr[31:28])
            OP_ADD:  m_rb[rd] = m_rb[rs] + m_rb[rt];
            OP_ADDI: m_rb[rd] = m_rb[rs] + imm;
            OP_LW:   m_rb[rd] = m_dm[imm[2:0]];
            OP_SW:   m_dm[imm[2:0]] = m_rb[rs];
            OP_HLT:  m_halt = 1'b1;
            default: ;
        endcase
        m_rb[0] = '0;
        if (!m_halt) m_pc = m_pc + 1'b1;
    endtask

    function automatic word_t model_word(input int w);
        if (w == 0) return {28'd0, m_pc};
        if (w <= 8) return m_rb[w - 1];
        return m_dm[w - 9];
    endfunction

    ////////////////////
    // serial drivers

    task automatic send_byte(input byte_t b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        @(posedge i_clock);
        for (int i = 0; i < 10; i++) begin
            i_uart_rx <= frame[i];
            repeat (CLKS) @(posedge i_clock);
        end
    endtask

    task automatic recv_byte(output byte_t b);
        @(posedge i_clock);
        while (o_uart_tx !== 1'b0) @(posedge i_clock);
        repeat (CLKS / 2) @(posedge i_clock);   // centre of the start bit
        for (int i = 0; i < 8; i++) begin
            repeat (CLKS) @(posedge i_clock);
            b[i] = o_uart_tx;
        end
        repeat (CLKS) @(posedge i_clock);
        if (o_uart_tx !== 1'b1) begin
            $display("stop bit on o_uart_tx was low, the frame is broken");
            err_count++;
        end
    endtask

    task automatic recv_dump();
        for (int i = 0; i < DUMP; i++) recv_byte(dump_q[i]);
    endtask

    task automatic command_dump(input byte_t cmd);
        fork
            send_byte(cmd);
            recv_dump();
        join
    endtask

    task automatic load_program(input int n);
        send_byte(`DBG_CMD_LOAD);
        send_byte(byte_t'(n));
        for (int w = 0; w < n; w++) begin
            for (int k = 0; k < 4; k++) send_byte(prog[w][8*k +: 8]);
        end
        model_clear();   // entering load clears the core
    endtask

    task automatic build_program();
        for (int i = 0; i < `DBG_IM_DEPTH; i++) prog[i] = '0;
        prog[0] = encode_instr(OP_ADDI, 3'd1, 3'd0, 3'd0, 16'(next_random() >> 16));
        prog[1] = encode_instr(OP_ADDI, 3'd2, 3'd0, 3'd0, 16'(next_random() >> 16));
        prog[2] = encode_instr(OP_ADDI, 3'd3, 3'd1, 3'd0, 16'(next_random() >> 16));
        prog[3] = encode_instr(OP_ADD,  3'd4, 3'd1, 3'd2, 16'd0);
        prog[4] = encode_instr(OP_SW,   3'd0, 3'd4, 3'd0, 16'd5);
        prog[5] = encode_instr(OP_LW,   3'd5, 3'd0, 3'd0, 16'd5);
        prog[6] = encode_instr(OP_ADD,  3'd6, 3'd5, 3'd3, 16'd0);
        prog[7] = encode_instr(OP_HLT,  3'd0, 3'd0, 3'd0, 16'd0);
    endtask

    function automatic word_t dump_word(input int w);
        return {dump_q[4*w+3], dump_q[4*w+2], dump_q[4*w+1], dump_q[4*w]};
    endfunction

    task automatic compare_dump();
        string name;
        for (int w = 0; w < 17; w++) begin
            if (w == 0) name = "dump pc";
            else if (w <= 8) name = $sformatf("dump r%0d", w - 1);
            else name = $sformatf("dump dm[%0d]", w - 9);
            check_word(name, model_word(w), dump_word(w));
        end
    endtask

    task automatic compare_dump_bytes();
        word_t exp;
        for (int i = 0; i < DUMP; i++) begin
            exp = model_word(i / 4);
            check_byte($sformatf("dump byte %0d", i), exp[8*(i%4) +: 8], dump_q[i]);
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        @(posedge i_clock);
        while (o_state !== DU_IDLE && n < 2 * BYTE_CYC) begin
            @(posedge i_clock);
            n++;
        end
        check_state("o_state", DU_IDLE, o_state);
    endtask

    task automatic expect_silence(input int cycles);
        logic seen;
        seen = 1'b0;
        for (int i = 0; i < cycles; i++) begin
            @(posedge i_clock);
            if (o_uart_tx !== 1'b1) seen = 1'b1;
            check_state("o_state", DU_IDLE, o_state);
        end
        if (seen) begin
            $display("a frame appeared on o_uart_tx after an unknown command");
            err_count++;
        end
    endtask

    ////////////////////
    // directed tests

    task automatic reset_values();
        int errs;
        errs = err_count;
        @(posedge i_clock);
        check_bit("o_uart_tx", 1'b1, o_uart_tx);
        check_bit("o_hlt", 1'b0, o_hlt);
        check_state("o_state", DU_IDLE, o_state);
        report_test("reset values", errs);
    endtask

    task automatic empty_program();
        int errs;
        errs = err_count;
        load_program(0);
        command_dump(`DBG_CMD_DUMP);
        compare_dump_bytes();
        wait_idle();
        report_test("empty program dump", errs);
    endtask

    task automatic run_to_halt();
        int errs;
        errs = err_count;
        build_program();
        load_program(PROG_LEN);
        for (int i = 0; i < 4 * PROG_LEN && !m_halt; i++) model_step();
        command_dump(`DBG_CMD_RUN);
        compare_dump();
        check_bit("o_hlt", 1'b1, o_hlt);
        wait_idle();
        report_test("run to halt", errs);
    endtask

    task automatic single_steps();
        int errs;
        errs = err_count;
        load_program(PROG_LEN);
        @(posedge i_clock);
        check_bit("o_hlt", 1'b0, o_hlt);
        // the last step comes after the hlt and must change nothing
        for (int k = 1; k <= PROG_LEN + 1; k++) begin
            model_step();
            command_dump(`DBG_CMD_STEP);
            if (k <= 3) check_word("dump pc", word_t'(k), dump_word(0));
            if (k == PROG_LEN + 1) compare_dump_bytes();
            else compare_dump();
            wait_idle();
        end
        check_bit("o_hlt", 1'b1, o_hlt);
        report_test("single steps", errs);
    endtask

    task automatic unknown_command();
        int errs;
        errs = err_count;
        send_byte(8'h58);
        expect_silence(2 * BYTE_CYC);
        command_dump(`DBG_CMD_DUMP);
        compare_dump();
        wait_idle();
        report_test("unknown command", errs);
    endtask

    initial begin
        i_clock   = 1'b0;
        i_reset   = 1'b1;
        i_uart_rx = 1'b1;
        repeat (16) @(posedge i_clock);
        i_reset <= 1'b0;

        reset_values();
        empty_program();
        run_to_halt();
        single_steps();
        unknown_command();

        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+design
design/dbg_pkg.sv
design/uart_rx.sv
design/uart_tx.sv
design/debug_unit.sv
design/data_path.sv
design/debug_top.sv
verification/debug_top_tb.sv
